// File: design/fabric_pkg.sv
package fabric_pkg;

    localparam int LUT_K    = 4;
    localparam int LUT_BITS = 1 << LUT_K;  // one truth table entry per input pattern

    typedef enum logic {
        BLE_COMB = 1'b0,                   // table output straight to the element output
        BLE_REG  = 1'b1                    // table output through the element register
    } ble_mode_e;

    // a switch output always takes the same track index from another side
    // the signal turns clockwise for SB_CW, so a north output takes the west input
    typedef enum logic [1:0] {
        SB_OFF      = 2'd0,
        SB_CW       = 2'd1,
        SB_STRAIGHT = 2'd2,
        SB_CCW      = 2'd3
    } sb_src_e;

    // side code held by each packed group, two bits per group, west in the lowest group
    localparam logic [7:0] SIDE_ORDER = {2'd3, 2'd2, 2'd1, 2'd0};

endpackage

// File: design/config_chain_seg.sv
`timescale 1ns/1ps

module config_chain_seg #(
    parameter int BITS = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            config_en,
    input  logic            config_in,
    output logic [BITS-1:0] cfg,
    output logic            config_out
);

    // bit 0 sits at the config_in end and data moves toward the top bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (config_en) begin
            cfg <= {cfg[BITS-2:0], config_in};
        end
    end

    assign config_out = cfg[BITS-1];  // feeds the next block on the chain

endmodule

// File: design/ble.sv
`timescale 1ns/1ps

module ble (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [fabric_pkg::LUT_K-1:0] lut_in,
    input  logic [fabric_pkg::LUT_BITS-1:0] lut_cfg,
    input  fabric_pkg::ble_mode_e        mode,
    output logic                         ble_out
);

    logic lut_out;
    logic lut_q;

    assign lut_out = lut_cfg[lut_in];  // truth table bit picked by the input pattern

    // runs every cycle, also while the chain is shifting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lut_q <= 1'b0;
        end else begin
            lut_q <= lut_out;
        end
    end

    always_comb begin
        case (mode)
            fabric_pkg::BLE_REG: begin
                ble_out = lut_q;
            end
            default: begin
                ble_out = lut_out;
            end
        endcase
    end

endmodule

// File: design/logic_block.sv
`timescale 1ns/1ps

module logic_block #(
    parameter int NUM_BLE = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         config_en,
    input  logic                         config_in,
    input  logic [fabric_pkg::LUT_K-1:0] lut_in,
    output logic [NUM_BLE-1:0]           ble_out,
    output logic                         config_out
);

    localparam int BLE_BITS = fabric_pkg::LUT_BITS + 1;  // table then mode bit
    localparam int SEG_BITS = NUM_BLE * BLE_BITS;

    logic [SEG_BITS-1:0] cfg;

    config_chain_seg #(
        .BITS(SEG_BITS)
    ) chain_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(config_in),
        .cfg(cfg),
        .config_out(config_out)
    );

    genvar k;

    generate
        for (k = 0; k < NUM_BLE; k = k + 1) begin : gen_ble
            logic [fabric_pkg::LUT_BITS-1:0] lut_cfg;
            fabric_pkg::ble_mode_e           mode;

            assign lut_cfg = cfg[k*BLE_BITS +: fabric_pkg::LUT_BITS];
            assign mode    = fabric_pkg::ble_mode_e'(cfg[k*BLE_BITS + fabric_pkg::LUT_BITS]);

            // all elements of the cluster see the same lookup inputs
            ble ble_i (
                .clk(clk),
                .rst_n(rst_n),
                .lut_in(lut_in),
                .lut_cfg(lut_cfg),
                .mode(mode),
                .ble_out(ble_out[k])
            );
        end
    endgenerate

endmodule

// File: design/switch_box.sv
`timescale 1ns/1ps

module switch_box #(
    parameter int TRACK_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   config_en,
    input  logic                   config_in,
    input  logic [TRACK_WIDTH-1:0] west_in,
    input  logic [TRACK_WIDTH-1:0] north_in,
    input  logic [TRACK_WIDTH-1:0] east_in,
    input  logic [TRACK_WIDTH-1:0] south_in,
    output logic [TRACK_WIDTH-1:0] west_out,
    output logic [TRACK_WIDTH-1:0] north_out,
    output logic [TRACK_WIDTH-1:0] east_out,
    output logic [TRACK_WIDTH-1:0] south_out,
    output logic                   config_out
);

    localparam int SEG_BITS = 4 * TRACK_WIDTH * 2;  // two code bits per output track

    logic [SEG_BITS-1:0]        cfg;
    logic [4*TRACK_WIDTH-1:0]   in_bus;
    logic [4*TRACK_WIDTH-1:0]   out_bus;

    config_chain_seg #(
        .BITS(SEG_BITS)
    ) chain_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(config_in),
        .cfg(cfg),
        .config_out(config_out)
    );

    // groups are packed west, north, east, south with west lowest
    assign in_bus = {south_in, east_in, north_in, west_in};

    assign west_out  = out_bus[0*TRACK_WIDTH +: TRACK_WIDTH];
    assign north_out = out_bus[1*TRACK_WIDTH +: TRACK_WIDTH];
    assign east_out  = out_bus[2*TRACK_WIDTH +: TRACK_WIDTH];
    assign south_out = out_bus[3*TRACK_WIDTH +: TRACK_WIDTH];

    genvar g, t;

    generate
        for (g = 0; g < 4; g = g + 1) begin : gen_side
            localparam logic [1:0] SIDE    = fabric_pkg::SIDE_ORDER[2*g +: 2];
            localparam logic [1:0] SRC_CW  = SIDE + 2'd3;  // side code arithmetic wraps mod 4
            localparam logic [1:0] SRC_ST  = SIDE + 2'd2;
            localparam logic [1:0] SRC_CCW = SIDE + 2'd1;

            for (t = 0; t < TRACK_WIDTH; t = t + 1) begin : gen_track
                fabric_pkg::sb_src_e src;

                assign src = fabric_pkg::sb_src_e'(cfg[2*(g*TRACK_WIDTH + t) +: 2]);

                always_comb begin
                    case (src)
                        fabric_pkg::SB_CW: begin
                            out_bus[g*TRACK_WIDTH + t] = in_bus[SRC_CW*TRACK_WIDTH + t];
                        end
                        fabric_pkg::SB_STRAIGHT: begin
                            out_bus[g*TRACK_WIDTH + t] = in_bus[SRC_ST*TRACK_WIDTH + t];
                        end
                        fabric_pkg::SB_CCW: begin
                            out_bus[g*TRACK_WIDTH + t] = in_bus[SRC_CCW*TRACK_WIDTH + t];
                        end
                        default: begin
                            out_bus[g*TRACK_WIDTH + t] = 1'b0;
                        end
                    endcase
                end
            end
        end
    endgenerate

endmodule

// File: design/connection_box.sv
`timescale 1ns/1ps

module connection_box #(
    parameter int NUM_BLE     = 2,
    parameter int TRACK_WIDTH = 4,
    parameter int PAD_WIDTH   = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         config_en,
    input  logic                         config_in,
    input  logic [TRACK_WIDTH-1:0]       track_in,
    input  logic [NUM_BLE-1:0]           ble_out,
    output logic [fabric_pkg::LUT_K-1:0] lut_in,
    output logic [TRACK_WIDTH-1:0]       track_out,
    output logic [PAD_WIDTH-1:0]         pad_out,
    output logic                         config_out
);

    localparam int NCAND     = 1 + TRACK_WIDTH + NUM_BLE;  // zero, tracks, logic outputs
    localparam int NRET      = 1 + NUM_BLE;                // zero, logic outputs
    localparam int SEL_W     = $clog2(NCAND);
    localparam int RET_W     = $clog2(NRET);
    localparam int RET_OFS   = fabric_pkg::LUT_K * SEL_W;
    localparam int PAD_OFS   = RET_OFS + TRACK_WIDTH * RET_W;
    localparam int SEG_BITS  = PAD_OFS + PAD_WIDTH * SEL_W;

    logic [SEG_BITS-1:0] cfg;
    logic [NCAND-1:0]    cand;
    logic [NRET-1:0]     ret_cand;

    config_chain_seg #(
        .BITS(SEG_BITS)
    ) chain_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(config_in),
        .cfg(cfg),
        .config_out(config_out)
    );

    // code 0 always picks the constant zero at the bottom of each list
    assign cand     = {ble_out, track_in, 1'b0};
    assign ret_cand = {ble_out, 1'b0};

    genvar i;

    generate
        for (i = 0; i < fabric_pkg::LUT_K; i = i + 1) begin : gen_lut_sel
            logic [SEL_W-1:0] sel;

            assign sel       = cfg[i*SEL_W +: SEL_W];
            assign lut_in[i] = (int'(sel) < NCAND) ? cand[sel] : 1'b0;  // spare codes give zero
        end

        // returned tracks go back into the south side of the switch box
        for (i = 0; i < TRACK_WIDTH; i = i + 1) begin : gen_ret_sel
            logic [RET_W-1:0] sel;

            assign sel          = cfg[RET_OFS + i*RET_W +: RET_W];
            assign track_out[i] = (int'(sel) < NRET) ? ret_cand[sel] : 1'b0;
        end

        for (i = 0; i < PAD_WIDTH; i = i + 1) begin : gen_pad_sel
            logic [SEL_W-1:0] sel;

            assign sel        = cfg[PAD_OFS + i*SEL_W +: SEL_W];
            assign pad_out[i] = (int'(sel) < NCAND) ? cand[sel] : 1'b0;
        end
    endgenerate

endmodule

// File: design/fabric_top.sv
`timescale 1ns/1ps

module fabric_top #(
    parameter int NUM_BLE     = 2,
    parameter int TRACK_WIDTH = 4,
    parameter int PAD_WIDTH   = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               config_en,
    input  logic                               config_in,
    input  logic [3*TRACK_WIDTH-1:0]           data_in,
    output logic [3*TRACK_WIDTH+PAD_WIDTH-1:0] data_out,
    output logic                               config_out
);

    logic                         chain_lb_sb;
    logic                         chain_sb_cb;
    logic [fabric_pkg::LUT_K-1:0] lut_in;
    logic [NUM_BLE-1:0]           ble_out;
    logic [TRACK_WIDTH-1:0]       sb_south_out;
    logic [TRACK_WIDTH-1:0]       cb_track_out;

    // chain runs config_in, logic block, switch box, connection box, config_out
    logic_block #(
        .NUM_BLE(NUM_BLE)
    ) logic_block_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(config_in),
        .lut_in(lut_in),
        .ble_out(ble_out),
        .config_out(chain_lb_sb)
    );

    switch_box #(
        .TRACK_WIDTH(TRACK_WIDTH)
    ) switch_box_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(chain_lb_sb),
        .west_in(data_in[0*TRACK_WIDTH +: TRACK_WIDTH]),
        .north_in(data_in[1*TRACK_WIDTH +: TRACK_WIDTH]),
        .east_in(data_in[2*TRACK_WIDTH +: TRACK_WIDTH]),
        .south_in(cb_track_out),
        .west_out(data_out[0*TRACK_WIDTH +: TRACK_WIDTH]),
        .north_out(data_out[1*TRACK_WIDTH +: TRACK_WIDTH]),
        .east_out(data_out[2*TRACK_WIDTH +: TRACK_WIDTH]),
        .south_out(sb_south_out),
        .config_out(chain_sb_cb)
    );

    connection_box #(
        .NUM_BLE(NUM_BLE),
        .TRACK_WIDTH(TRACK_WIDTH),
        .PAD_WIDTH(PAD_WIDTH)
    ) connection_box_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(chain_sb_cb),
        .track_in(sb_south_out),
        .ble_out(ble_out),
        .lut_in(lut_in),
        .track_out(cb_track_out),
        .pad_out(data_out[3*TRACK_WIDTH +: PAD_WIDTH]),  // pads sit above the track groups
        .config_out(config_out)
    );

endmodule

// File: dv/fabric_props.sv
`timescale 1ns/1ps

module fabric_props (
    input logic        clk,
    input logic        rst_n,
    input logic        config_en,
    input logic        config_in,
    input logic [15:0] data_out,
    input logic        config_out,
    input logic [3:0]  lut_in,
    input logic [33:0] lb_cfg,
    input logic [2:0]  pad1_sel
);

    logic [7:0]  en_run;    // consecutive shifting cycles, saturates
    logic        cfg_seen;  // set by the first shift after reset
    logic [15:0] table1;
    logic        reg_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_run   <= '0;
            cfg_seen <= 1'b0;
        end else begin
            if (config_en) begin
                cfg_seen <= 1'b1;
            end
            if (!config_en) begin
                en_run <= '0;
            end else if (en_run != 8'hff) begin
                en_run <= en_run + 8'd1;
            end
        end
    end

    assign table1   = lb_cfg[32:17];
    assign reg_next = table1[lut_in];  // value element 1 registers at this edge

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_seen |-> (data_out == 16'd0 && config_out == 1'b0))
        else $error("outputs not zero after reset");

    chain_pass_through: assert property (@(posedge clk) disable iff (!rst_n)
        (en_run >= 8'd98) |-> (config_out == $past(config_in, 98)))
        else $error("config_out differs from config_in 98 shifts earlier");

    registered_pad: assert property (@(posedge clk) disable iff (!rst_n)
        (lb_cfg[33] && pad1_sel == 3'd6 && !$past(config_en)) |-> (data_out[13] == $past(reg_next)))
        else $error("pad 1 does not follow the registered element 1");

endmodule

bind fabric_top fabric_props props_i (
    .clk(clk),
    .rst_n(rst_n),
    .config_en(config_en),
    .config_in(config_in),
    .data_out(data_out),
    .config_out(config_out),
    .lut_in(lut_in),
    .lb_cfg(logic_block_i.cfg),
    .pad1_sel(connection_box_i.cfg[25:23])
);

// File: dv/fabric_tb.sv
`timescale 1ns/1ps

module fabric_tb;

    localparam int CHAIN_BITS = 98;
    localparam int MAX_CYCLES = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  config_en;
    logic                  config_in;
    logic [11:0]           data_in;
    logic [15:0]           data_out;
    logic                  config_out;
    integer                seed;
    int                    value_errors;
    int                    timeout_fails;
    int                    unfinished_fails;
    int                    cycles;
    int                    route_checks;
    int                    lookup_checks;
    int                    test_mode;  // 0 idle, 4 routing, 5 lookup
    logic [15:0]           table0;
    logic [15:0]           table1;
    logic [3:0]            last_north;
    logic                  reg_valid;
    logic                  hold_valid;
    logic                  last_cfg_out;
    logic [31:0]           rnd;

    fabric_top dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .config_en(config_en),
        .config_in(config_in),
        .data_in(data_in),
        .data_out(data_out),
        .config_out(config_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic expect_value(input logic [15:0] got, input logic [15:0] exp, input string what);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // shifts the top position first so that position p ends up holding img[p]
    task automatic load_image(input logic [CHAIN_BITS-1:0] img);
        for (int i = CHAIN_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            #1;
            config_en = 1'b1;
            config_in = img[i];
        end
        @(posedge clk);
        #1;
        config_en = 1'b0;
        config_in = 1'b0;
    endtask

    function automatic logic [CHAIN_BITS-1:0] route_image();
        logic [CHAIN_BITS-1:0] img;
        img = '0;
        for (int t = 0; t < 4; t++) begin
            img[34 + 2*t +: 2]       = fabric_pkg::SB_STRAIGHT;  // west output
            img[34 + 2*(4 + t) +: 2] = fabric_pkg::SB_CW;        // north output
            img[34 + 2*(8 + t) +: 2] = fabric_pkg::SB_CCW;       // east output
        end
        return img;
    endfunction

    function automatic logic [CHAIN_BITS-1:0] lookup_image(input logic [15:0] t0,
                                                           input logic [15:0] t1);
        logic [CHAIN_BITS-1:0] img;
        img = '0;
        img[0 +: 16] = t0;
        img[16]      = fabric_pkg::BLE_COMB;
        img[17 +: 16] = t1;
        img[33]      = fabric_pkg::BLE_REG;
        for (int t = 0; t < 4; t++) begin
            img[34 + 2*(12 + t) +: 2] = fabric_pkg::SB_STRAIGHT;  // south carries north
            img[66 + 3*t +: 3]        = 3'(t + 1);                // lookup input t from south track t
        end
        img[34 + 2*8 +: 2] = fabric_pkg::SB_CCW;  // east track 0 takes the returned element 0
        img[78 +: 2]       = 2'd1;
        img[86 +: 3]       = 3'd5;
        img[89 +: 3]       = 3'd6;
        return img;
    endfunction

    task automatic run_checks();
        logic [3:0] north;
        logic       b0;
        north = data_in[7:4];
        b0    = table0[north];
        if (hold_valid && !config_en) begin
            expect_value({15'd0, config_out}, {15'd0, last_cfg_out}, "config_out during hold");
        end
        hold_valid   = !config_en;
        last_cfg_out = config_out;
        if (test_mode == 4) begin
            expect_value(data_out, {8'h00, data_in[3:0], data_in[11:8]}, "routed data_out");
            route_checks++;
        end else if (test_mode == 5) begin
            // the register needs one cycle with the image fully in place
            if (reg_valid) begin
                expect_value(data_out, {2'b00, table1[last_north], b0, 3'b000, b0, 8'h00},
                             "lookup data_out");
                lookup_checks++;
            end
            reg_valid  = 1'b1;
            last_north = north;
        end
    endtask

    always begin
        @(posedge clk);
        #7;
        if (rst_n) begin
            run_checks();
        end
    end

    task automatic print_counts();
        $display("checks done: %0d value errors, %0d timeouts, %0d unfinished sequences",
                 value_errors, timeout_fails, unfinished_fails);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: the test sequence did not end within %0d cycles", cycles);
            timeout_fails++;
            print_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic drive_data(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            rnd     = $random(seed);
            data_in = rnd[11:0];
        end
    endtask

    initial begin
        seed = 32'h04e0_e86f;
        rst_n = 1'b0;
        config_en = 1'b0;
        config_in = 1'b0;
        data_in = '0;
        value_errors = 0;
        timeout_fails = 0;
        unfinished_fails = 0;
        cycles = 0;
        route_checks = 0;
        lookup_checks = 0;
        test_mode = 0;
        reg_valid = 1'b0;
        hold_valid = 1'b0;
        last_cfg_out = 1'b0;
        last_north = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // one random bit in three keeps every select window free of element codes
        for (int n = 0; n < 200 + CHAIN_BITS; n++) begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            config_en = 1'b1;
            config_in = (n % 3 == 0) ? rnd[0] : 1'b0;
        end
        @(posedge clk);
        #1;
        config_en = 1'b0;
        repeat (20) begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            config_in = rnd[0];
        end
        config_in = 1'b0;
        load_image(route_image());
        test_mode = 4;
        drive_data(40);
        @(posedge clk);
        #1;
        test_mode = 0;
        data_in   = '0;
        load_image('0);  // tables are all zero while the lookup image passes the selects
        rnd    = $random(seed);
        table0 = rnd[15:0] & ~16'h6812;  // bits under a shifting element code stay zero
        table1 = rnd[31:16] & ~16'h44be;
        load_image(lookup_image(table0, table1));
        reg_valid = 1'b0;
        test_mode = 5;
        drive_data(60);
        @(posedge clk);
        #1;
        test_mode = 0;
        repeat (2) @(posedge clk);
        if (route_checks < 40 || lookup_checks < 60) begin
            $display("test sequence ended after %0d routing and %0d lookup checks",
                     route_checks, lookup_checks);
            unfinished_fails++;
        end
        print_counts();
        if (value_errors == 0 && timeout_fails == 0 && unfinished_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
design/fabric_pkg.sv
design/config_chain_seg.sv
design/ble.sv
design/logic_block.sv
design/switch_box.sv
design/connection_box.sv
design/fabric_top.sv
dv/fabric_props.sv
dv/fabric_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fabric_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
